// ==== rtl/mem_cfg_pkg.sv ====
package mem_cfg_pkg;

	// ========================================
	// Application interface widths
	// ========================================

	// Line address as seen by the DDR controller
	localparam int APP_ADDR_W = 29;

	// One line is 16 bytes
	localparam int APP_DATA_W = 128;

	// One mask bit per byte of the line
	localparam int APP_MASK_W = APP_DATA_W / 8;

	// ========================================
	// Types
	// ========================================

	typedef logic [APP_ADDR_W-1:0] app_addr_t;

	typedef logic [APP_DATA_W-1:0] app_data_t;

	// A set bit keeps the byte unchanged in memory
	typedef logic [APP_MASK_W-1:0] app_mask_t;

	typedef logic [2:0] app_cmd_t;

	// ========================================
	// Commands
	// ========================================

	// Only plain line writes and line reads are issued
	localparam app_cmd_t CMD_WRITE = 3'd0;
	localparam app_cmd_t CMD_READ = 3'd1;

endpackage

// ==== rtl/chan_pkg.sv ====
package chan_pkg;

	// ========================================
	// Client channels
	// ========================================

	// CPU port and I/O port
	localparam int NUM_CH = 2;

	// Byte address on the client bus
	localparam int CH_ADDR_W = 32;

	typedef logic [CH_ADDR_W-1:0] ch_addr_t;

	// Data words of the two ports
	typedef logic [127:0] cpu_dat_t;
	typedef logic [31:0] io_dat_t;

	// Port number, also the arbiter grant
	typedef logic chan_id_t;

	localparam chan_id_t CH_CPU = 1'b0;
	localparam chan_id_t CH_IO = 1'b1;

endpackage

// ==== rtl/chan_port.sv ====
`timescale 1ns/1ns

module chan_port #(
	parameter type dat_t = chan_pkg::io_dat_t
) (
	input  logic                        mem_ui_clk,
	input  logic                        mem_ui_rst,
	input  logic                        cyc_i,
	input  logic                        stb_i,
	input  logic                        we_i,
	input  logic [$bits(dat_t)/8-1:0]   sel_i,
	input  chan_pkg::ch_addr_t          adr_i,
	input  dat_t                        dat_i,
	input  logic                        done_i,
	input  mem_cfg_pkg::app_data_t      rd_line_i,
	output logic                        ack_o,
	output dat_t                        dat_o,
	output logic                        req_o,
	output logic                        req_we_o,
	output mem_cfg_pkg::app_addr_t      req_addr_o,
	output mem_cfg_pkg::app_data_t      req_data_o,
	output mem_cfg_pkg::app_mask_t      req_mask_o
);

	// Lane geometry follows from the port word
	localparam int DAT_W = $bits(dat_t);
	localparam int SEL_W = DAT_W / 8;
	localparam int LANES = mem_cfg_pkg::APP_DATA_W / DAT_W;

	// Keeps only the address bits that pick a lane inside the line
	localparam logic [3:0] OFS_MASK = 4'(~(SEL_W - 1));

	logic                   ack_q;
	logic [3:0]             ofs_q;
	logic [3:0]             byte_ofs;
	logic                   take;
	mem_cfg_pkg::app_mask_t sel_ext;

	// ========================================
	// Request capture
	// ========================================

	// Byte offset of the addressed lane within the line
	assign byte_ofs = adr_i[3:0] & OFS_MASK;
	assign sel_ext = mem_cfg_pkg::app_mask_t'(sel_i);

	// A new request waits until the previous ack has been seen off
	assign take = cyc_i && stb_i && !req_o && !ack_q;

	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			req_o <= 1'b0;
			ack_q <= 1'b0;
		end else begin
			if (take)
				req_o <= 1'b1;
			else if (done_i)
				req_o <= 1'b0;

			if (done_i)
				ack_q <= 1'b1;
			else if (ack_q && !stb_i)
				ack_q <= 1'b0;
		end
	end

	// Line request fields, loaded once per access
	always_ff @(posedge mem_ui_clk) begin
		if (take) begin
			req_we_o <= we_i;
			req_addr_o <= mem_cfg_pkg::app_addr_t'(adr_i[chan_pkg::CH_ADDR_W-1:4]);
			// Same word on every lane and the mask picks the lane that lands
			req_data_o <= {LANES{dat_i}};
			ofs_q <= byte_ofs;
			if (we_i)
				req_mask_o <= ~(sel_ext << byte_ofs);
			else
				req_mask_o <= '0;
		end
	end

	// ========================================
	// Completion
	// ========================================

	// Pull the addressed lane out of the returned line
	always_ff @(posedge mem_ui_clk) begin
		if (done_i)
			dat_o <= dat_t'(rd_line_i >> {ofs_q, 3'b000});
	end

	// Drops in the same cycle as stb_i
	assign ack_o = ack_q && stb_i;

endmodule

// ==== rtl/chan_arbiter.sv ====
`timescale 1ns/1ns

module chan_arbiter (
	input  logic                             mem_ui_clk,
	input  logic                             mem_ui_rst,
	input  logic                             cpu_req_i,
	input  logic                             cpu_we_i,
	input  mem_cfg_pkg::app_addr_t           cpu_addr_i,
	input  mem_cfg_pkg::app_data_t           cpu_data_i,
	input  mem_cfg_pkg::app_mask_t           cpu_mask_i,
	input  logic                             io_req_i,
	input  logic                             io_we_i,
	input  mem_cfg_pkg::app_addr_t           io_addr_i,
	input  mem_cfg_pkg::app_data_t           io_data_i,
	input  mem_cfg_pkg::app_mask_t           io_mask_i,
	input  logic                             cmd_ready_i,
	input  logic                             seq_done_i,
	output logic                             cmd_valid_o,
	output logic                             cmd_we_o,
	output mem_cfg_pkg::app_addr_t           cmd_addr_o,
	output mem_cfg_pkg::app_data_t           cmd_data_o,
	output mem_cfg_pkg::app_mask_t           cmd_mask_o,
	output logic [chan_pkg::NUM_CH-1:0]      done_o
);

	logic               busy_q;
	chan_pkg::chan_id_t grant_q;
	chan_pkg::chan_id_t prio_q;
	chan_pkg::chan_id_t pick;

	// Alternate on a tie, otherwise the lone requester wins
	always_comb begin
		if (cpu_req_i && io_req_i)
			pick = prio_q;
		else if (io_req_i)
			pick = chan_pkg::CH_IO;
		else
			pick = chan_pkg::CH_CPU;
	end

	// ========================================
	// Grant and command handshake
	// ========================================

	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			busy_q <= 1'b0;
			grant_q <= chan_pkg::CH_CPU;
			prio_q <= chan_pkg::CH_CPU;
			cmd_valid_o <= 1'b0;
		end else if (!busy_q && (cpu_req_i || io_req_i)) begin
			busy_q <= 1'b1;
			grant_q <= pick;
			cmd_valid_o <= 1'b1;
			// The other port gets the next tie
			if (pick == chan_pkg::CH_CPU)
				prio_q <= chan_pkg::CH_IO;
			else
				prio_q <= chan_pkg::CH_CPU;
		end else begin
			if (cmd_valid_o && cmd_ready_i)
				cmd_valid_o <= 1'b0;
			if (seq_done_i)
				busy_q <= 1'b0;
		end
	end

	// Command fields of the winning port
	always_ff @(posedge mem_ui_clk) begin
		if (!busy_q) begin
			if (pick == chan_pkg::CH_IO) begin
				cmd_we_o <= io_we_i;
				cmd_addr_o <= io_addr_i;
				cmd_data_o <= io_data_i;
				cmd_mask_o <= io_mask_i;
			end else begin
				cmd_we_o <= cpu_we_i;
				cmd_addr_o <= cpu_addr_i;
				cmd_data_o <= cpu_data_i;
				cmd_mask_o <= cpu_mask_i;
			end
		end
	end

	// Completion goes back to the port holding the grant
	always_comb begin
		done_o = '0;
		if (busy_q && seq_done_i)
			done_o[grant_q] = 1'b1;
	end

endmodule

// ==== rtl/app_sequencer.sv ====
`timescale 1ns/1ns

module app_sequencer (
	input  logic                        mem_ui_clk,
	input  logic                        mem_ui_rst,
	input  logic                        calib_complete_i,
	input  logic                        cmd_valid_i,
	input  logic                        cmd_we_i,
	input  mem_cfg_pkg::app_addr_t      cmd_addr_i,
	input  mem_cfg_pkg::app_data_t      cmd_data_i,
	input  mem_cfg_pkg::app_mask_t      cmd_mask_i,
	input  logic                        app_rdy_i,
	input  logic                        app_wdf_rdy_i,
	input  mem_cfg_pkg::app_data_t      app_rd_data_i,
	input  logic                        app_rd_data_valid_i,
	output logic                        cmd_ready_o,
	output logic                        app_en_o,
	output mem_cfg_pkg::app_cmd_t       app_cmd_o,
	output mem_cfg_pkg::app_addr_t      app_addr_o,
	output mem_cfg_pkg::app_data_t      app_wdf_data_o,
	output mem_cfg_pkg::app_mask_t      app_wdf_mask_o,
	output logic                        app_wdf_wren_o,
	output logic                        app_wdf_end_o,
	output logic                        done_o,
	output mem_cfg_pkg::app_data_t      rd_line_o
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_CMD,
		S_WDATA,
		S_RWAIT
	} state_t;

	state_t state_q;
	logic   cmd_xfer;

	// Nothing is accepted before calibration is done
	assign cmd_ready_o = (state_q == S_IDLE) && calib_complete_i;
	assign cmd_xfer = cmd_valid_i && cmd_ready_o;

	// ========================================
	// Control FSM
	// ========================================

	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			state_q <= S_IDLE;
			app_en_o <= 1'b0;
			app_wdf_wren_o <= 1'b0;
			app_wdf_end_o <= 1'b0;
			done_o <= 1'b0;
		end else begin
			// done_o is a single-cycle pulse
			done_o <= 1'b0;
			case (state_q)
				S_IDLE: begin
					if (cmd_xfer) begin
						app_en_o <= 1'b1;
						state_q <= S_CMD;
					end
				end
				S_CMD: begin
					// Command held until the controller takes it
					if (app_rdy_i) begin
						app_en_o <= 1'b0;
						if (app_cmd_o == mem_cfg_pkg::CMD_WRITE) begin
							app_wdf_wren_o <= 1'b1;
							app_wdf_end_o <= 1'b1;
							state_q <= S_WDATA;
						end else begin
							state_q <= S_RWAIT;
						end
					end
				end
				S_WDATA: begin
					// A line is one beat so wren and end go together
					if (app_wdf_rdy_i) begin
						app_wdf_wren_o <= 1'b0;
						app_wdf_end_o <= 1'b0;
						done_o <= 1'b1;
						state_q <= S_IDLE;
					end
				end
				S_RWAIT: begin
					if (app_rd_data_valid_i) begin
						done_o <= 1'b1;
						state_q <= S_IDLE;
					end
				end
				default: begin
					state_q <= S_IDLE;
				end
			endcase
		end
	end

	// ========================================
	// Payload registers
	// ========================================

	always_ff @(posedge mem_ui_clk) begin
		if (cmd_xfer) begin
			if (cmd_we_i)
				app_cmd_o <= mem_cfg_pkg::CMD_WRITE;
			else
				app_cmd_o <= mem_cfg_pkg::CMD_READ;
			app_addr_o <= cmd_addr_i;
			app_wdf_data_o <= cmd_data_i;
			app_wdf_mask_o <= cmd_mask_i;
		end
	end

	// Line kept until the next read returns
	always_ff @(posedge mem_ui_clk) begin
		if (state_q == S_RWAIT && app_rd_data_valid_i)
			rd_line_o <= app_rd_data_i;
	end

endmodule

// ==== rtl/mpmc_top.sv ====
`timescale 1ns/1ns

module mpmc_top (
	input  logic                        mem_ui_clk,
	input  logic                        mem_ui_rst,
	input  logic                        calib_complete_i,
	// CPU channel
	input  logic                        cpu_cyc_i,
	input  logic                        cpu_stb_i,
	input  logic                        cpu_we_i,
	input  logic [15:0]                 cpu_sel_i,
	input  chan_pkg::ch_addr_t          cpu_adr_i,
	input  chan_pkg::cpu_dat_t          cpu_dat_i,
	output chan_pkg::cpu_dat_t          cpu_dat_o,
	output logic                        cpu_ack_o,
	// I/O channel
	input  logic                        io_cyc_i,
	input  logic                        io_stb_i,
	input  logic                        io_we_i,
	input  logic [3:0]                  io_sel_i,
	input  chan_pkg::ch_addr_t          io_adr_i,
	input  chan_pkg::io_dat_t           io_dat_i,
	output chan_pkg::io_dat_t           io_dat_o,
	output logic                        io_ack_o,
	// DDR controller application interface
	output logic                        app_en_o,
	output mem_cfg_pkg::app_cmd_t       app_cmd_o,
	output mem_cfg_pkg::app_addr_t      app_addr_o,
	output mem_cfg_pkg::app_data_t      app_wdf_data_o,
	output mem_cfg_pkg::app_mask_t      app_wdf_mask_o,
	output logic                        app_wdf_wren_o,
	output logic                        app_wdf_end_o,
	input  logic                        app_rdy_i,
	input  logic                        app_wdf_rdy_i,
	input  mem_cfg_pkg::app_data_t      app_rd_data_i,
	input  logic                        app_rd_data_valid_i
);

	logic                          cpu_req;
	logic                          cpu_req_we;
	mem_cfg_pkg::app_addr_t        cpu_req_addr;
	mem_cfg_pkg::app_data_t        cpu_req_data;
	mem_cfg_pkg::app_mask_t        cpu_req_mask;
	logic                          io_req;
	logic                          io_req_we;
	mem_cfg_pkg::app_addr_t        io_req_addr;
	mem_cfg_pkg::app_data_t        io_req_data;
	mem_cfg_pkg::app_mask_t        io_req_mask;
	logic [chan_pkg::NUM_CH-1:0]   port_done;
	logic                          cmd_valid;
	logic                          cmd_ready;
	logic                          cmd_we;
	mem_cfg_pkg::app_addr_t        cmd_addr;
	mem_cfg_pkg::app_data_t        cmd_data;
	mem_cfg_pkg::app_mask_t        cmd_mask;
	logic                          seq_done;
	mem_cfg_pkg::app_data_t        rd_line;

	// ========================================
	// Port capture
	// ========================================

	chan_port #(.dat_t(chan_pkg::cpu_dat_t)) u_port_cpu (
		.mem_ui_clk (mem_ui_clk),
		.mem_ui_rst (mem_ui_rst),
		.cyc_i      (cpu_cyc_i),
		.stb_i      (cpu_stb_i),
		.we_i       (cpu_we_i),
		.sel_i      (cpu_sel_i),
		.adr_i      (cpu_adr_i),
		.dat_i      (cpu_dat_i),
		.done_i     (port_done[chan_pkg::CH_CPU]),
		.rd_line_i  (rd_line),
		.ack_o      (cpu_ack_o),
		.dat_o      (cpu_dat_o),
		.req_o      (cpu_req),
		.req_we_o   (cpu_req_we),
		.req_addr_o (cpu_req_addr),
		.req_data_o (cpu_req_data),
		.req_mask_o (cpu_req_mask)
	);

	chan_port #(.dat_t(chan_pkg::io_dat_t)) u_port_io (
		.mem_ui_clk (mem_ui_clk),
		.mem_ui_rst (mem_ui_rst),
		.cyc_i      (io_cyc_i),
		.stb_i      (io_stb_i),
		.we_i       (io_we_i),
		.sel_i      (io_sel_i),
		.adr_i      (io_adr_i),
		.dat_i      (io_dat_i),
		.done_i     (port_done[chan_pkg::CH_IO]),
		.rd_line_i  (rd_line),
		.ack_o      (io_ack_o),
		.dat_o      (io_dat_o),
		.req_o      (io_req),
		.req_we_o   (io_req_we),
		.req_addr_o (io_req_addr),
		.req_data_o (io_req_data),
		.req_mask_o (io_req_mask)
	);

	// ========================================
	// Arbitration and sequencing
	// ========================================

	chan_arbiter u_arbiter (
		.mem_ui_clk  (mem_ui_clk),
		.mem_ui_rst  (mem_ui_rst),
		.cpu_req_i   (cpu_req),
		.cpu_we_i    (cpu_req_we),
		.cpu_addr_i  (cpu_req_addr),
		.cpu_data_i  (cpu_req_data),
		.cpu_mask_i  (cpu_req_mask),
		.io_req_i    (io_req),
		.io_we_i     (io_req_we),
		.io_addr_i   (io_req_addr),
		.io_data_i   (io_req_data),
		.io_mask_i   (io_req_mask),
		.cmd_ready_i (cmd_ready),
		.seq_done_i  (seq_done),
		.cmd_valid_o (cmd_valid),
		.cmd_we_o    (cmd_we),
		.cmd_addr_o  (cmd_addr),
		.cmd_data_o  (cmd_data),
		.cmd_mask_o  (cmd_mask),
		.done_o      (port_done)
	);

	app_sequencer u_sequencer (
		.mem_ui_clk          (mem_ui_clk),
		.mem_ui_rst          (mem_ui_rst),
		.calib_complete_i    (calib_complete_i),
		.cmd_valid_i         (cmd_valid),
		.cmd_we_i            (cmd_we),
		.cmd_addr_i          (cmd_addr),
		.cmd_data_i          (cmd_data),
		.cmd_mask_i          (cmd_mask),
		.app_rdy_i           (app_rdy_i),
		.app_wdf_rdy_i       (app_wdf_rdy_i),
		.app_rd_data_i       (app_rd_data_i),
		.app_rd_data_valid_i (app_rd_data_valid_i),
		.cmd_ready_o         (cmd_ready),
		.app_en_o            (app_en_o),
		.app_cmd_o           (app_cmd_o),
		.app_addr_o          (app_addr_o),
		.app_wdf_data_o      (app_wdf_data_o),
		.app_wdf_mask_o      (app_wdf_mask_o),
		.app_wdf_wren_o      (app_wdf_wren_o),
		.app_wdf_end_o       (app_wdf_end_o),
		.done_o              (seq_done),
		.rd_line_o           (rd_line)
	);

endmodule

// ==== verif/mpmc_properties.sv ====
`timescale 1ns/1ns

module mpmc_properties (
	input logic mem_ui_clk,
	input logic mem_ui_rst,
	input logic app_en_i,
	input logic app_rdy_i,
	input logic wdf_wren_i,
	input logic wdf_end_i,
	input logic cpu_stb_i,
	input logic cpu_ack_i,
	input logic io_stb_i,
	input logic io_ack_i
);

	// ========================================
	// Application interface
	// ========================================

	// A command stays up until the controller takes it
	app_en_held: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
		app_en_i && !app_rdy_i |=> app_en_i)
		else $error("app_en_o dropped before app_rdy_i was seen");

	// Single-beat lines
	wdf_end_with_wren: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
		wdf_wren_i == wdf_end_i)
		else $error("app_wdf_end_o differs from app_wdf_wren_o");

	// ========================================
	// Client buses
	// ========================================

	cpu_ack_needs_stb: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
		cpu_ack_i |-> cpu_stb_i)
		else $error("cpu_ack_o high without cpu_stb_i");

	io_ack_needs_stb: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
		io_ack_i |-> io_stb_i)
		else $error("io_ack_o high without io_stb_i");

endmodule

// ==== verif/mpmc_tb.sv ====
`timescale 1ns/1ns

module mpmc_tb;

	localparam int ACK_TIMEOUT = 400;
	localparam int CALIB_HOLD = 30;
	localparam int TRAFFIC_OPS = 40;

	logic                        mem_ui_clk;
	logic                        mem_ui_rst;
	logic                        calib_complete_i;
	logic                        cpu_cyc_i;
	logic                        cpu_stb_i;
	logic                        cpu_we_i;
	logic [15:0]                 cpu_sel_i;
	chan_pkg::ch_addr_t          cpu_adr_i;
	chan_pkg::cpu_dat_t          cpu_dat_i;
	chan_pkg::cpu_dat_t          cpu_dat_o;
	logic                        cpu_ack_o;
	logic                        io_cyc_i;
	logic                        io_stb_i;
	logic                        io_we_i;
	logic [3:0]                  io_sel_i;
	chan_pkg::ch_addr_t          io_adr_i;
	chan_pkg::io_dat_t           io_dat_i;
	chan_pkg::io_dat_t           io_dat_o;
	logic                        io_ack_o;
	logic                        app_en_o;
	mem_cfg_pkg::app_cmd_t       app_cmd_o;
	mem_cfg_pkg::app_addr_t      app_addr_o;
	mem_cfg_pkg::app_data_t      app_wdf_data_o;
	mem_cfg_pkg::app_mask_t      app_wdf_mask_o;
	logic                        app_wdf_wren_o;
	logic                        app_wdf_end_o;
	logic                        app_rdy_i;
	logic                        app_wdf_rdy_i;
	mem_cfg_pkg::app_data_t      app_rd_data_i;
	logic                        app_rd_data_valid_i;

	// Memory model state and the expected contents
	logic [127:0] mem_model [logic [28:0]];
	logic [127:0] ref_mem [logic [28:0]];
	logic [28:0]  wr_key;
	logic [28:0]  rd_key;
	logic [15:0]  last_wmask;
	bit           rd_pending;
	int           rd_delay;
	bit           stall_en;
	int           n_checks;
	int           n_errors;
	int           cpu_reqs;
	int           io_reqs;
	int           cpu_acks;
	int           io_acks;

	mpmc_top u_mpmc_top (.*);

	bind mpmc_top mpmc_properties u_properties (
		.mem_ui_clk (mem_ui_clk),
		.mem_ui_rst (mem_ui_rst),
		.app_en_i   (app_en_o),
		.app_rdy_i  (app_rdy_i),
		.wdf_wren_i (app_wdf_wren_o),
		.wdf_end_i  (app_wdf_end_o),
		.cpu_stb_i  (cpu_stb_i),
		.cpu_ack_i  (cpu_ack_o),
		.io_stb_i   (io_stb_i),
		.io_ack_i   (io_ack_o)
	);

	always #5 mem_ui_clk = ~mem_ui_clk;

	always @(posedge cpu_ack_o) cpu_acks++;
	always @(posedge io_ack_o) io_acks++;

	// ========================================
	// Helpers
	// ========================================

	// Contents of a line nobody has written yet
	function automatic logic [127:0] fill_line(input logic [28:0] key);
		return {3'b101, key, 3'b011, ~key, 3'b110, key ^ 29'h0f0f_0f0f, 3'b000,
			{key[13:0], key[28:14]}};
	endfunction

	function automatic logic [127:0] model_line(input logic [28:0] key);
		return mem_model.exists(key) ? mem_model[key] : fill_line(key);
	endfunction

	function automatic logic [127:0] ref_line(input logic [28:0] key);
		return ref_mem.exists(key) ? ref_mem[key] : fill_line(key);
	endfunction

	function automatic logic [127:0] rand_line();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	// A narrow read returns the 32-bit lane picked by adr[3:2]
	function automatic logic [127:0] expect_read(input chan_pkg::chan_id_t port,
		input logic [31:0] adr);
		logic [127:0] line;
		line = ref_line({1'b0, adr[31:4]});
		if (port == chan_pkg::CH_IO)
			return {96'h0, line[adr[3:2]*32 +: 32]};
		return line;
	endfunction

	task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic ref_write(input chan_pkg::chan_id_t port, input logic [15:0] sel,
		input logic [31:0] adr, input logic [127:0] wdat);
		logic [127:0] line;
		logic [28:0]  key;
		int           base;
		key = {1'b0, adr[31:4]};
		line = ref_line(key);
		base = 4 * adr[3:2];
		if (port == chan_pkg::CH_IO) begin
			for (int j = 0; j < 4; j++)
				if (sel[j])
					line[(base+j)*8 +: 8] = wdat[j*8 +: 8];
		end else begin
			for (int i = 0; i < 16; i++)
				if (sel[i])
					line[i*8 +: 8] = wdat[i*8 +: 8];
		end
		ref_mem[key] = line;
	endtask

	// One bus cycle on either port, ended by the acknowledge
	task automatic bus_access(input chan_pkg::chan_id_t port, input bit we,
		input logic [15:0] sel, input logic [31:0] adr, input logic [127:0] wdat,
		output logic [127:0] rdat);
		int waited;
		bit got;
		@(negedge mem_ui_clk);
		if (port == chan_pkg::CH_IO) begin
			io_cyc_i = 1'b1;
			io_stb_i = 1'b1;
			io_we_i = we;
			io_sel_i = sel[3:0];
			io_adr_i = adr;
			io_dat_i = wdat[31:0];
			io_reqs++;
		end else begin
			cpu_cyc_i = 1'b1;
			cpu_stb_i = 1'b1;
			cpu_we_i = we;
			cpu_sel_i = sel;
			cpu_adr_i = adr;
			cpu_dat_i = wdat;
			cpu_reqs++;
		end
		got = 1'b0;
		waited = 0;
		while (!got && waited < ACK_TIMEOUT) begin
			@(negedge mem_ui_clk);
			if ((port == chan_pkg::CH_IO) ? io_ack_o : cpu_ack_o)
				got = 1'b1;
			else
				waited++;
		end
		if (!got) begin
			n_errors++;
			$display("ERROR: port %0d got no acknowledge within %0d cycles", port, ACK_TIMEOUT);
		end
		// Strobe drops as soon as the acknowledge is seen
		if (port == chan_pkg::CH_IO) begin
			rdat = {96'h0, io_dat_o};
			io_cyc_i = 1'b0;
			io_stb_i = 1'b0;
			io_we_i = 1'b0;
		end else begin
			rdat = cpu_dat_o;
			cpu_cyc_i = 1'b0;
			cpu_stb_i = 1'b0;
			cpu_we_i = 1'b0;
		end
	endtask

	task automatic write_access(input chan_pkg::chan_id_t port, input logic [15:0] sel,
		input logic [31:0] adr, input logic [127:0] wdat);
		logic [127:0] rdat;
		bus_access(port, 1'b1, sel, adr, wdat, rdat);
		ref_write(port, sel, adr, wdat);
	endtask

	task automatic read_and_check(input chan_pkg::chan_id_t port, input logic [31:0] adr);
		logic [127:0] rdat;
		bus_access(port, 1'b0, 16'h0, adr, rand_line(), rdat);
		if (port == chan_pkg::CH_IO)
			check("io_dat_o", rdat, expect_read(port, adr));
		else
			check("cpu_dat_o", rdat, expect_read(port, adr));
	endtask

	task automatic random_traffic(input chan_pkg::chan_id_t port, input int n,
		input int first_line);
		logic [31:0] adr;
		logic [15:0] sel;
		logic [3:0]  idx;
		for (int k = 0; k < n; k++) begin
			idx = 4'(first_line + $urandom_range(7, 0));
			if (port == chan_pkg::CH_IO) begin
				adr = {24'h0, idx, 2'($urandom_range(3, 0)), 2'b00};
				sel = {12'h0, 4'($urandom_range(15, 1))};
			end else begin
				adr = {24'h0, idx, 4'h0};
				sel = 16'($urandom);
			end
			if ($urandom_range(1, 0) == 1)
				write_access(port, sel, adr, rand_line());
			else
				read_and_check(port, adr);
		end
	endtask

	// ========================================
	// DDR application interface model
	// ========================================

	always @(negedge mem_ui_clk) begin
		logic [127:0] line;
		if (mem_ui_rst) begin
			app_rdy_i = 1'b0;
			app_wdf_rdy_i = 1'b0;
			app_rd_data_valid_i = 1'b0;
			rd_pending = 1'b0;
		end else begin
			app_rd_data_valid_i = 1'b0;
			if (rd_pending) begin
				rd_delay--;
				if (rd_delay == 0) begin
					app_rd_data_i = model_line(rd_key);
					app_rd_data_valid_i = 1'b1;
					rd_pending = 1'b0;
				end
			end
			app_rdy_i = !stall_en || ($urandom_range(3, 0) != 0);
			app_wdf_rdy_i = !stall_en || ($urandom_range(3, 0) != 0);
			// Handshakes that complete on the next rising edge
			if (app_en_o && app_rdy_i) begin
				if (app_cmd_o == mem_cfg_pkg::CMD_READ) begin
					rd_key = app_addr_o;
					rd_delay = $urandom_range(8, 1);
					rd_pending = 1'b1;
				end else begin
					wr_key = app_addr_o;
				end
			end
			if (app_wdf_wren_o && app_wdf_rdy_i) begin
				line = model_line(wr_key);
				for (int i = 0; i < 16; i++)
					if (!app_wdf_mask_o[i])
						line[i*8 +: 8] = app_wdf_data_o[i*8 +: 8];
				mem_model[wr_key] = line;
				last_wmask = app_wdf_mask_o;
			end
		end
	end

	// ========================================
	// Test sequence
	// ========================================

	initial begin
		logic [31:0]  adr;
		logic [15:0]  sel;
		logic [15:0]  exp_mask;
		int           lane;
		void'($urandom(20));
		mem_ui_clk = 1'b0;
		mem_ui_rst = 1'b1;
		calib_complete_i = 1'b0;
		cpu_cyc_i = 1'b0;
		cpu_stb_i = 1'b0;
		cpu_we_i = 1'b0;
		cpu_sel_i = '0;
		cpu_adr_i = '0;
		cpu_dat_i = '0;
		io_cyc_i = 1'b0;
		io_stb_i = 1'b0;
		io_we_i = 1'b0;
		io_sel_i = '0;
		io_adr_i = '0;
		io_dat_i = '0;
		app_rdy_i = 1'b0;
		app_wdf_rdy_i = 1'b0;
		app_rd_data_i = '0;
		app_rd_data_valid_i = 1'b0;
		stall_en = 1'b0;
		repeat (10) @(negedge mem_ui_clk);
		mem_ui_rst = 1'b0;

		// Nothing moves before calibration
		sel = 16'($urandom);
		adr = 32'h0000_0030;
		fork
			write_access(chan_pkg::CH_CPU, sel, adr, rand_line());
			begin
				repeat (CALIB_HOLD) begin
					@(negedge mem_ui_clk);
					check("cpu_ack_o", cpu_ack_o, 1'b0);
					check("io_ack_o", io_ack_o, 1'b0);
					check("app_en_o", app_en_o, 1'b0);
					check("app_wdf_wren_o", app_wdf_wren_o, 1'b0);
				end
				calib_complete_i = 1'b1;
			end
		join
		stall_en = 1'b1;

		// CPU write with a random select, then read the line back
		for (int k = 0; k < 6; k++) begin
			adr = {24'h0, 4'($urandom_range(15, 0)), 4'h0};
			write_access(chan_pkg::CH_CPU, 16'($urandom), adr, rand_line());
			read_and_check(chan_pkg::CH_CPU, adr);
		end

		// I/O write to one lane, check the mask, read it back both ways
		for (int k = 0; k < 6; k++) begin
			lane = $urandom_range(3, 0);
			sel = {12'h0, 4'($urandom_range(15, 1))};
			adr = {24'h0, 4'($urandom_range(15, 0)), 2'(lane), 2'b00};
			exp_mask = ~(sel << (4 * lane));
			write_access(chan_pkg::CH_IO, sel, adr, rand_line());
			check("app_wdf_mask_o", last_wmask, exp_mask);
			read_and_check(chan_pkg::CH_IO, adr);
			read_and_check(chan_pkg::CH_CPU, {adr[31:4], 4'h0});
		end

		// CPU writes seen through every I/O lane
		for (int k = 0; k < 4; k++) begin
			adr = {24'h0, 4'($urandom_range(15, 0)), 4'h0};
			write_access(chan_pkg::CH_CPU, 16'($urandom), adr, rand_line());
			for (int j = 0; j < 4; j++)
				read_and_check(chan_pkg::CH_IO, {adr[31:4], 2'(j), 2'b00});
		end

		// Both ports at once on separate lines
		fork
			random_traffic(chan_pkg::CH_CPU, TRAFFIC_OPS, 0);
			random_traffic(chan_pkg::CH_IO, TRAFFIC_OPS, 8);
		join
		repeat (3) @(negedge mem_ui_clk);
		check("cpu_ack_o count", cpu_acks, cpu_reqs);
		check("io_ack_o count", io_acks, io_reqs);

		$display("Checks: %0d  Errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== filelist.f ====
rtl/mem_cfg_pkg.sv
rtl/chan_pkg.sv
rtl/chan_port.sv
rtl/chan_arbiter.sv
rtl/app_sequencer.sv
rtl/mpmc_top.sv
verif/mpmc_properties.sv
verif/mpmc_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "Cannot enter the project directory"
	exit 1
fi

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f --top-module mpmc_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vmpmc_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

grep -q "^TEST PASSED$" "$LOG"
if [ $? -ne 0 ]; then
	echo "Simulation failed"
	exit 1
fi

echo "Simulation passed"
exit 0
